//--- include/inj_macros.svh
`ifndef INJ_MACROS_SVH
`define INJ_MACROS_SVH

// width of a network flit and of a source word
`define INJ_FLIT_W 32

// flits in a TASK_ALLOCATION header, the payload size counts all but the first two
`define INJ_HEADER_FLITS 13

`define INJ_SVC_TASK_ALLOCATION 32'h40

// mapper address carried in header flit 4
`define INJ_MAPPER_ADDR 32'h0

`endif

//--- design/inj_pkg.sv
`default_nettype none

`include "inj_macros.svh"

package inj_pkg;

    typedef logic [`INJ_FLIT_W-1:0] flit_t;    // flit or source word
    typedef logic [7:0]             task_id_t; // app id or task index
    typedef logic [3:0]             hdr_idx_t; // position in header

    // descriptor fetch stage
    typedef enum logic [2:0] {
        APP,
        TARGET,
        TEXT,
        DATA,
        BSS,
        ENTRY,
        HANDOFF,
        WAIT_ACK
    } fetch_state_t;

    // packet transmit stage
    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        BODY,
        ACK
    } tx_state_t;

endpackage

`default_nettype wire

//--- design/inj_descriptor_fetch.sv
`default_nettype none

`include "inj_macros.svh"

module inj_descriptor_fetch
    import inj_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,

    input  logic  src_rx_i,
    input  flit_t src_data_i,
    input  logic  body_credit_i,
    output logic  src_credit_o,

    output logic  desc_req_o,
    input  logic  desc_ack_i,
    output flit_t desc_target_o,
    output flit_t desc_text_o,
    output flit_t desc_data_o,
    output flit_t desc_bss_o,
    output flit_t desc_entry_o,
    output flit_t desc_size_o,
    output flit_t desc_task_word_o
);

    fetch_state_t state_q;
    fetch_state_t state_d;

    task_id_t task_cnt_q;
    task_id_t task_idx_q;
    task_id_t app_id_q;

    flit_t target_q;
    flit_t text_q;
    flit_t data_q;
    flit_t bss_q;
    flit_t entry_q;
    flit_t size_q;

    logic src_accept;
    logic last_task;

    // body words pass through to the tx stage once the header is handed off
    assign src_credit_o = (state_q inside {APP, TARGET, TEXT, DATA, BSS, ENTRY}) ? 1'b1
                                                                                : body_credit_i;

    assign src_accept = src_rx_i && src_credit_o;
    assign last_task  = (task_idx_q == task_cnt_q - 8'd1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            APP:      state_d = src_accept ? TARGET : APP;
            TARGET:   state_d = src_accept ? TEXT : TARGET;
            TEXT:     state_d = src_accept ? DATA : TEXT;
            DATA:     state_d = src_accept ? BSS : DATA;
            BSS:      state_d = src_accept ? ENTRY : BSS;
            ENTRY:    state_d = src_accept ? HANDOFF : ENTRY;
            HANDOFF:  state_d = desc_ack_i ? WAIT_ACK : HANDOFF; // packet fully sent
            WAIT_ACK: begin
                if (!desc_ack_i) begin
                    state_d = last_task ? APP : TARGET;
                end
            end
            default:  state_d = APP;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= APP;
            task_cnt_q <= '0;
            task_idx_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == APP && src_accept) begin
                task_cnt_q <= src_data_i[7:0];
                task_idx_q <= '0;
            end else if (state_q == WAIT_ACK && !desc_ack_i && !last_task) begin
                task_idx_q <= task_idx_q + 8'd1; // handshake closed
            end
        end
    end

    // size goes text, text+data, words, then plus header flits past the size flit
    always_ff @(posedge clk_i) begin
        if (src_accept) begin
            case (state_q)
                APP: begin
                    app_id_q <= src_data_i[15:8];
                end
                TARGET: begin
                    target_q <= src_data_i;
                end
                TEXT: begin
                    text_q <= src_data_i;
                    size_q <= src_data_i;
                end
                DATA: begin
                    data_q <= src_data_i;
                    size_q <= size_q + src_data_i;
                end
                BSS: begin
                    bss_q  <= src_data_i;
                    size_q <= size_q >> 2; // bytes to words
                end
                ENTRY: begin
                    entry_q <= src_data_i;
                    size_q  <= size_q + flit_t'(`INJ_HEADER_FLITS - 2);
                end
                default: ;
            endcase
        end
    end

    assign desc_req_o       = (state_q == HANDOFF);
    assign desc_target_o    = target_q;
    assign desc_text_o      = text_q;
    assign desc_data_o      = data_q;
    assign desc_bss_o       = bss_q;
    assign desc_entry_o     = entry_q;
    assign desc_size_o      = size_q;
    assign desc_task_word_o = flit_t'({app_id_q, task_idx_q});

endmodule

`default_nettype wire

//--- design/inj_packet_tx.sv
`default_nettype none

`include "inj_macros.svh"

module inj_packet_tx
    import inj_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,

    input  logic  desc_req_i,
    output logic  desc_ack_o,
    input  flit_t desc_target_i,
    input  flit_t desc_text_i,
    input  flit_t desc_data_i,
    input  flit_t desc_bss_i,
    input  flit_t desc_entry_i,
    input  flit_t desc_size_i,
    input  flit_t desc_task_word_i,

    input  logic  src_rx_i,
    input  flit_t src_data_i,
    output logic  body_credit_o,

    output logic  noc_tx_o,
    input  logic  noc_credit_i,
    output flit_t noc_data_o
);

    tx_state_t state_q;
    tx_state_t state_d;

    flit_t    hdr_q [`INJ_HEADER_FLITS];
    hdr_idx_t hdr_idx_q;
    flit_t    body_cnt_q; // body words still to forward

    logic hdr_last;
    logic body_xfer;

    assign hdr_last  = (hdr_idx_q == hdr_idx_t'(`INJ_HEADER_FLITS - 1));
    assign body_xfer = src_rx_i && noc_credit_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    state_d = desc_req_i ? HEADER : IDLE;
            HEADER: begin
                if (noc_credit_i && hdr_last) begin
                    state_d = (body_cnt_q == '0) ? ACK : BODY; // empty body skips BODY
                end
            end
            BODY: begin
                if (body_xfer && body_cnt_q == flit_t'(1)) begin
                    state_d = ACK;
                end
            end
            ACK:     state_d = desc_req_i ? ACK : IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            hdr_idx_q  <= '0;
            body_cnt_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && desc_req_i) begin
                body_cnt_q <= desc_size_i - flit_t'(`INJ_HEADER_FLITS - 2);
            end else if (state_q == BODY && body_xfer) begin
                body_cnt_q <= body_cnt_q - flit_t'(1);
            end
            if (state_q == HEADER && noc_credit_i) begin
                hdr_idx_q <= hdr_last ? '0 : hdr_idx_q + 4'd1;
            end
        end
    end

    // TASK_ALLOCATION header, unused flits stay zero
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE && desc_req_i) begin
            for (int i = 0; i < `INJ_HEADER_FLITS; i++) begin
                hdr_q[i] <= '0;
            end
            hdr_q[0]  <= desc_target_i;
            hdr_q[1]  <= desc_size_i;
            hdr_q[2]  <= `INJ_SVC_TASK_ALLOCATION;
            hdr_q[3]  <= desc_task_word_i; // app id and task index
            hdr_q[4]  <= `INJ_MAPPER_ADDR;
            hdr_q[9]  <= desc_data_i;
            hdr_q[10] <= desc_text_i;
            hdr_q[11] <= desc_bss_i;
            hdr_q[12] <= desc_entry_i;
        end
    end

    always_comb begin
        noc_tx_o      = 1'b0;
        noc_data_o    = src_data_i;
        body_credit_o = 1'b0;
        case (state_q)
            HEADER: begin
                noc_tx_o   = 1'b1;
                noc_data_o = hdr_q[hdr_idx_q];
            end
            BODY: begin
                noc_tx_o      = src_rx_i; // source words go straight out
                body_credit_o = noc_credit_i;
            end
            default: ;
        endcase
    end

    assign desc_ack_o = (state_q == ACK);

endmodule

`default_nettype wire

//--- design/injector_top.sv
`default_nettype none

module injector_top
    import inj_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,

    input  logic  src_rx_i,
    output logic  src_credit_o,
    input  flit_t src_data_i,

    output logic  noc_tx_o,
    input  logic  noc_credit_i,
    output flit_t noc_data_o
);

    logic  desc_req;
    logic  desc_ack;
    logic  body_credit;
    flit_t desc_target;
    flit_t desc_text;
    flit_t desc_data;
    flit_t desc_bss;
    flit_t desc_entry;
    flit_t desc_size;
    flit_t desc_task_word;

    inj_descriptor_fetch inj_descriptor_fetch_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .src_rx_i         (src_rx_i),
        .src_data_i       (src_data_i),
        .body_credit_i    (body_credit),
        .src_credit_o     (src_credit_o),
        .desc_req_o       (desc_req),
        .desc_ack_i       (desc_ack),
        .desc_target_o    (desc_target),
        .desc_text_o      (desc_text),
        .desc_data_o      (desc_data),
        .desc_bss_o       (desc_bss),
        .desc_entry_o     (desc_entry),
        .desc_size_o      (desc_size),
        .desc_task_word_o (desc_task_word)
    );

    // one packet in flight, both stages share the source port
    inj_packet_tx inj_packet_tx_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .desc_req_i       (desc_req),
        .desc_ack_o       (desc_ack),
        .desc_target_i    (desc_target),
        .desc_text_i      (desc_text),
        .desc_data_i      (desc_data),
        .desc_bss_i       (desc_bss),
        .desc_entry_i     (desc_entry),
        .desc_size_i      (desc_size),
        .desc_task_word_i (desc_task_word),
        .src_rx_i         (src_rx_i),
        .src_data_i       (src_data_i),
        .body_credit_o    (body_credit),
        .noc_tx_o         (noc_tx_o),
        .noc_credit_i     (noc_credit_i),
        .noc_data_o       (noc_data_o)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tb_checker.sv
`default_nettype none

`include "inj_macros.svh"

module tb_checker
    import inj_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  src_rx_i,
    input  logic  src_credit_i,
    input  flit_t src_data_i,
    input  logic  noc_tx_i,
    input  logic  noc_credit_i,
    input  flit_t noc_data_i,
    input  logic  done_i,
    output int    mismatch_cnt_o,
    output int    extra_cnt_o,
    output int    missing_cnt_o,
    output int    packets_o
);

    flit_t    exp_q [$]; // flits still owed on the network
    int       len_q [$]; // lengths of pending packets
    flit_t    desc [5];  // target, text, data, bss, entry
    int       field;     // 0 app word, 1 to 5 descriptor, 6 body
    int       body_left;
    int       tasks_left;
    int       flit_pos;
    task_id_t app_id;
    task_id_t task_idx;

    initial begin
        mismatch_cnt_o = 0;
        extra_cnt_o    = 0;
        missing_cnt_o  = 0;
        packets_o      = 0;
        field          = 0;
        body_left      = 0;
        tasks_left     = 0;
        flit_pos       = 0;
        app_id         = '0;
        task_idx       = '0;
    end

    task push_header();
        flit_t body_words;
        body_words = (desc[1] + desc[2]) >> 2; // sizes in bytes
        body_left  = int'(body_words);
        exp_q.push_back(desc[0]);
        exp_q.push_back(body_words + flit_t'(`INJ_HEADER_FLITS - 2));
        exp_q.push_back(`INJ_SVC_TASK_ALLOCATION);
        exp_q.push_back({16'h0, app_id, task_idx});
        exp_q.push_back(`INJ_MAPPER_ADDR);
        repeat (4) exp_q.push_back(flit_t'(0));
        exp_q.push_back(desc[2]);
        exp_q.push_back(desc[1]);
        exp_q.push_back(desc[3]);
        exp_q.push_back(desc[4]);
        len_q.push_back(`INJ_HEADER_FLITS + body_left);
    endtask

    task next_task();
        task_idx   = task_idx + 8'd1;
        tasks_left = tasks_left - 1;
        field      = (tasks_left == 0) ? 0 : 1;
    endtask

    task take_word(input flit_t w);
        if (field == 0) begin
            app_id     = w[15:8];
            tasks_left = int'(w[7:0]);
            task_idx   = '0;
            field      = 1;
        end else if (field < 5) begin
            desc[field - 1] = w;
            field = field + 1;
        end else if (field == 5) begin
            desc[4] = w;
            push_header();
            if (body_left == 0) next_task();
            else field = 6;
        end else begin
            exp_q.push_back(w); // body word passes unchanged
            body_left = body_left - 1;
            if (body_left == 0) next_task();
        end
    endtask

    task check_flit(input flit_t f);
        flit_t exp;
        if (exp_q.size() == 0) begin
            extra_cnt_o = extra_cnt_o + 1;
            $display("%0t: extra flit %08h on the network port, no packet pending", $time, f);
        end else begin
            exp = exp_q.pop_front();
            if (f !== exp) begin
                mismatch_cnt_o = mismatch_cnt_o + 1;
                $display("ERROR %0t noc_data_o packet %0d flit %0d: expected %08h, actual %08h",
                         $time, packets_o, flit_pos, exp, f);
            end
            flit_pos = flit_pos + 1;
            if (flit_pos == len_q[0]) begin
                len_q.delete(0);
                flit_pos  = 0;
                packets_o = packets_o + 1;
            end
        end
    endtask

    // source word first, a body word leaves in the cycle it arrives
    always @(negedge clk_i) begin
        if (rst_ni && src_rx_i && src_credit_i) take_word(src_data_i);
        if (rst_ni && noc_tx_i && noc_credit_i) check_flit(noc_data_i);
    end

    always @(posedge done_i) begin
        missing_cnt_o = exp_q.size();
        if (missing_cnt_o != 0) begin
            $display("%0d expected flits never appeared on the network port", missing_cnt_o);
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_injector.sv
`default_nettype none

`include "inj_macros.svh"

module tb_injector
    import inj_pkg::*;
();

    localparam int NUM_APPS  = 2;
    localparam int NUM_TASKS = 5;

    localparam task_id_t APP_ID    [NUM_APPS] = '{8'h05, 8'h1a};
    localparam int       APP_TASKS [NUM_APPS] = '{3, 2};

    // target, text, data, bss, entry
    localparam flit_t TASK_TBL [NUM_TASKS][5] = '{
        '{32'h0000_0102, 32'd16, 32'd8,  32'd32, 32'h0000_0080},
        '{32'h0000_0201, 32'd0,  32'd0,  32'd4,  32'h0000_0000}, // no body
        '{32'h0000_0303, 32'd40, 32'd12, 32'd0,  32'h0000_0100},
        '{32'h0000_0001, 32'd8,  32'd4,  32'd16, 32'h0000_0040},
        '{32'h0000_0300, 32'd24, 32'd0,  32'd8,  32'h0000_0020}
    };

    logic  clk;
    logic  rst_n;
    logic  src_rx;
    logic  src_credit;
    flit_t src_data;
    logic  noc_tx;
    logic  noc_credit;
    flit_t noc_data;
    logic  done;
    logic  timed_out;
    int    mismatch_cnt;
    int    extra_cnt;
    int    missing_cnt;
    int    packets;
    int    total_tasks;
    int    word_idx;
    int    cycles;
    int    cycle_limit;
    flit_t stream_q [$];
    logic [31:0] lcg_state;

    tb_clock_gen clock_gen_i (.clk_o(clk), .rst_no(rst_n));

    injector_top injector_top_i (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .src_rx_i     (src_rx),
        .src_credit_o (src_credit),
        .src_data_i   (src_data),
        .noc_tx_o     (noc_tx),
        .noc_credit_i (noc_credit),
        .noc_data_o   (noc_data)
    );

    tb_checker checker_i (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .src_rx_i       (src_rx),
        .src_credit_i   (src_credit),
        .src_data_i     (src_data),
        .noc_tx_i       (noc_tx),
        .noc_credit_i   (noc_credit),
        .noc_data_i     (noc_data),
        .done_i         (done),
        .mismatch_cnt_o (mismatch_cnt),
        .extra_cnt_o    (extra_cnt),
        .missing_cnt_o  (missing_cnt),
        .packets_o      (packets)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // app word, then per task five descriptor words and the body
    task build_stream();
        int t;
        int n_body;
        t = 0;
        total_tasks = 0;
        for (int a = 0; a < NUM_APPS; a++) begin
            stream_q.push_back({16'h0, APP_ID[a], 8'(APP_TASKS[a])});
            total_tasks = total_tasks + APP_TASKS[a];
            for (int k = 0; k < APP_TASKS[a]; k++) begin
                for (int f = 0; f < 5; f++) begin
                    stream_q.push_back(TASK_TBL[t][f]);
                end
                n_body = int'((TASK_TBL[t][1] + TASK_TBL[t][2]) >> 2);
                repeat (n_body) begin
                    lcg_state = lcg_step(lcg_state);
                    stream_q.push_back(lcg_state);
                end
                t = t + 1;
            end
        end
    endtask

    initial begin
        timed_out = 1'b0;
        cycles    = 0;
        @(posedge rst_n);
        cycle_limit = 8 * stream_q.size() + 200;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        timed_out = 1'b1;
    end

    initial begin
        src_rx     = 1'b0;
        src_data   = '0;
        noc_credit = 1'b0;
        done       = 1'b0;
        word_idx   = 0;
        lcg_state  = 32'h24a7;
        build_stream();
        @(posedge rst_n);
        while (packets < total_tasks && !timed_out) begin
            @(negedge clk);
            if (src_rx && src_credit) word_idx = word_idx + 1;
            @(posedge clk);
            lcg_state = lcg_step(lcg_state);
            noc_credit <= (lcg_state[31:30] != 2'b00); // stalls about one cycle in four
            if (word_idx < stream_q.size()) begin
                src_rx   <= (lcg_state[29:28] != 2'b00);
                src_data <= stream_q[word_idx];
            end else begin
                src_rx <= 1'b0;
            end
        end
        noc_credit <= 1'b1; // room for any stray flit
        repeat (20) @(posedge clk);
        done = 1'b1;
        @(negedge clk);
        if (timed_out) begin
            $display("timeout after %0d cycles, %0d of %0d packets sent",
                     cycle_limit, packets, total_tasks);
        end
        $display("errors: %0d mismatched, %0d extra, %0d missing flits",
                 mismatch_cnt, extra_cnt, missing_cnt);
        if (!timed_out && mismatch_cnt + extra_cnt + missing_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
design/inj_pkg.sv
design/inj_descriptor_fetch.sv
design/inj_packet_tx.sv
design/injector_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_injector.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the injector testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f sources.f --top-module tb_injector \
    -Mdir obj_dir -o tb_injector_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_injector_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
exit 0
